// File: cu_consts.svh
`ifndef CU_CONSTS_SVH
`define CU_CONSTS_SVH

// Word widths
`define CU_INSTR_W      32      // Instruction word
`define CU_STATE_W      8       // Microstate address
`define CU_NEXT_W       3       // Next-state code field
`define CU_ALUOP_W      4       // ALU operation field

// Fixed microstate addresses
`define CU_ADDR_RESET   0       // Entered while CLR is low
`define CU_ADDR_FETCH   1       // First state of the fetch sequence

// Instruction class field
`define CU_CLASS_HI     27
`define CU_CLASS_LO     25

// Single instruction bits used by the decoder
`define CU_BIT_P        24      // Pre-index, also test/compare and link
`define CU_BIT_U        23      // Up/down, also test/compare
`define CU_BIT_W        21      // Write-back
`define CU_BIT_L        20      // Load when set, store when clear

// Class codes in bits 27 to 25
`define CU_CLASS_DP_REG 3'd0    // Data processing, register or shift
`define CU_CLASS_DP_IMM 3'd1    // Data processing, immediate
`define CU_CLASS_LS_IMM 3'd2    // Load/store, immediate offset
`define CU_CLASS_LS_REG 3'd3    // Load/store, register offset
`define CU_CLASS_BRANCH 3'd5    // Branch and branch with link

`endif

// File: cu_pkg.sv
`include "cu_consts.svh"

package cuPkg;

    // Microprogram addresses of the states in use
    typedef enum logic [`CU_STATE_W-1:0] {
        sReset      = `CU_ADDR_RESET,
        sFetchAddr  = `CU_ADDR_FETCH,
        sFetchRead  = 2,    // Waits on moc
        sFetchIr    = 3,
        sCondCheck  = 4,
        sDataProc   = 5,
        sTestComp   = 6,
        sBranchLink = 7,
        sBranch     = 8,
        sLoadAddr   = 9,
        sLoadRead   = 10,   // Waits on moc
        sLoadWrite  = 11,
        sStoreAddr  = 12,
        sStoreData  = 13,
        sStoreWrite = 14    // Waits on moc
    } microState;

    // Next-state codes, the two-way ones choose by the status bit
    typedef enum logic [`CU_NEXT_W-1:0] {
        nEncoder    = 3'd0, // Decoder start state
        nFetch      = 3'd1, // Fixed fetch state
        nCtrlReg    = 3'd2, // Microword address field
        nIncr       = 3'd3, // Current state plus one
        nStsCrEnc   = 3'd4, // Address or decoder
        nStsCrInc   = 3'd5, // Address or increment
        nStsEncInc  = 3'd6, // Decoder or increment
        nStsCrFetch = 3'd7  // Address or fetch
    } nextCode;

    typedef enum logic {
        stsMoc  = 1'b0,     // Memory operation complete
        stsCond = 1'b1      // Condition check result
    } statusSel;

    typedef enum logic [`CU_ALUOP_W-1:0] {
        aluAddFour  = 4'd0, // PC plus four, also the idle code
        aluInstr    = 4'd1, // Operation taken from the instruction
        aluAddrCalc = 4'd2, // Base plus offset
        aluPassB    = 4'd3,
        aluLink     = 4'd4  // Return address to the link register
    } aluOp;

    typedef struct packed {
        logic rfLoad;
        logic irLoad;
        logic marLoad;
        logic mdrLoad;
        logic srLoad;
        logic memWrite;
        logic memValid;
        aluOp aluOp;
    } ctrlWord;

    typedef struct packed {
        nextCode   next;
        logic      invert;      // Inverts the selected status bit
        statusSel  status;
        microState crAddress;   // Target of the address-field codes
        ctrlWord   ctrl;
    } microWord;

endpackage

// File: seqIf.sv
interface seqIf;
    import cuPkg::*;

    nextCode   next;
    logic      invert;
    statusSel  status;
    microState crAddress;

    modport store (
        output next,
        output invert,
        output status,
        output crAddress
    );

    modport seq (
        input  next,
        input  invert,
        input  status,
        input  crAddress
    );
endinterface

// File: instrDecoder.sv
`include "cu_consts.svh"

module instrDecoder (
    input  logic [`CU_INSTR_W-1:0] instr,
    output cuPkg::microState       startState
);
    import cuPkg::*;

    logic [2:0] instrClass;
    logic       pBit;
    logic       uBit;
    logic       wBit;
    logic       lBit;

    assign instrClass = instr[`CU_CLASS_HI:`CU_CLASS_LO];
    assign pBit       = instr[`CU_BIT_P];
    assign uBit       = instr[`CU_BIT_U];
    assign wBit       = instr[`CU_BIT_W];
    assign lBit       = instr[`CU_BIT_L];

    always_comb begin
        startState = sReset;    // Unsupported forms restart the unit
        case (instrClass)
            `CU_CLASS_DP_REG,
            `CU_CLASS_DP_IMM: begin
                if (pBit && !uBit) begin
                    startState = sTestComp;     // TST, TEQ, CMP, CMN
                end else begin
                    startState = sDataProc;
                end
            end
            `CU_CLASS_LS_IMM,
            `CU_CLASS_LS_REG: begin
                // Offset addressing only, indexed forms stay at reset
                if (pBit && !wBit) begin
                    startState = lBit ? sLoadAddr : sStoreAddr;
                end
            end
            `CU_CLASS_BRANCH: begin
                startState = pBit ? sBranchLink : sBranch;
            end
            default: begin
                startState = sReset;
            end
        endcase
    end

endmodule

// File: controlStore.sv
module controlStore (
    input  logic             CLK,
    input  logic             CLR,
    input  cuPkg::microState nextState,
    output cuPkg::microState currentState,
    seqIf.store              seq,
    output cuPkg::ctrlWord   ctrl
);
    import cuPkg::*;

    // Control words, one per distinct set of active signals
    localparam ctrlWord ctlNone = '{aluOp: aluAddFour, default: 1'b0};
    localparam ctrlWord ctlFetchAddr = '{marLoad: 1'b1, aluOp: aluAddFour, default: 1'b0};
    localparam ctrlWord ctlMemRead =
        '{memValid: 1'b1, mdrLoad: 1'b1, aluOp: aluAddFour, default: 1'b0};
    localparam ctrlWord ctlFetchIr =
        '{irLoad: 1'b1, rfLoad: 1'b1, aluOp: aluAddFour, default: 1'b0};
    localparam ctrlWord ctlDataProc = '{rfLoad: 1'b1, aluOp: aluInstr, default: 1'b0};
    localparam ctrlWord ctlTestComp = '{srLoad: 1'b1, aluOp: aluInstr, default: 1'b0};
    localparam ctrlWord ctlLink = '{rfLoad: 1'b1, aluOp: aluLink, default: 1'b0};
    localparam ctrlWord ctlBranch = '{rfLoad: 1'b1, aluOp: aluAddrCalc, default: 1'b0};
    localparam ctrlWord ctlAddrCalc = '{marLoad: 1'b1, aluOp: aluAddrCalc, default: 1'b0};
    localparam ctrlWord ctlLoadWrite = '{rfLoad: 1'b1, aluOp: aluPassB, default: 1'b0};
    localparam ctrlWord ctlStoreData = '{mdrLoad: 1'b1, aluOp: aluPassB, default: 1'b0};
    localparam ctrlWord ctlMemWrite =
        '{memValid: 1'b1, memWrite: 1'b1, aluOp: aluAddFour, default: 1'b0};

    // Also returned for any address outside the microprogram
    localparam microWord resetWord = '{nFetch, 1'b0, stsMoc, sReset, ctlNone};

    microWord mWord;

    always_ff @(posedge CLK or negedge CLR) begin
        if (!CLR) begin
            currentState <= sReset;
        end else begin
            currentState <= nextState;
        end
    end

    // Microprogram table, fields are next, invert, status, address, controls
    always_comb begin
        case (currentState)
            sReset:      mWord = resetWord;
            sFetchAddr:  mWord = '{nIncr, 1'b0, stsMoc, sReset, ctlFetchAddr};
            sFetchRead:  mWord = '{nStsCrInc, 1'b1, stsMoc, sFetchRead, ctlMemRead};
            sFetchIr:    mWord = '{nIncr, 1'b0, stsMoc, sReset, ctlFetchIr};
            sCondCheck:  mWord = '{nStsCrEnc, 1'b1, stsCond, sFetchAddr, ctlNone};
            sDataProc:   mWord = '{nFetch, 1'b0, stsMoc, sReset, ctlDataProc};
            sTestComp:   mWord = '{nFetch, 1'b0, stsMoc, sReset, ctlTestComp};
            sBranchLink: mWord = '{nIncr, 1'b0, stsMoc, sReset, ctlLink};
            sBranch:     mWord = '{nFetch, 1'b0, stsMoc, sReset, ctlBranch};
            sLoadAddr:   mWord = '{nIncr, 1'b0, stsMoc, sReset, ctlAddrCalc};
            sLoadRead:   mWord = '{nStsCrInc, 1'b1, stsMoc, sLoadRead, ctlMemRead};
            sLoadWrite:  mWord = '{nFetch, 1'b0, stsMoc, sReset, ctlLoadWrite};
            sStoreAddr:  mWord = '{nIncr, 1'b0, stsMoc, sReset, ctlAddrCalc};
            sStoreData:  mWord = '{nIncr, 1'b0, stsMoc, sReset, ctlStoreData};
            sStoreWrite: mWord = '{nStsCrFetch, 1'b1, stsMoc, sStoreWrite, ctlMemWrite};
            default:     mWord = resetWord;
        endcase
    end

    assign seq.next      = mWord.next;
    assign seq.invert    = mWord.invert;
    assign seq.status    = mWord.status;
    assign seq.crAddress = mWord.crAddress;
    assign ctrl          = mWord.ctrl;      // Held for the whole state

endmodule

// File: microSequencer.sv
module microSequencer (
    seqIf.seq                seq,
    input  cuPkg::microState currentState,
    input  cuPkg::microState startState,
    input  logic             moc,
    input  logic             condTrue,
    output cuPkg::microState nextState
);
    import cuPkg::*;

    // Sources of the next-address multiplexer
    typedef enum logic [1:0] {
        srcEncoder = 2'd0,
        srcFetch   = 2'd1,
        srcCtrlReg = 2'd2,
        srcIncr    = 2'd3
    } addrSrc;

    logic   stsRaw;
    logic   sts;
    addrSrc src;

    assign stsRaw = (seq.status == stsCond) ? condTrue : moc;
    assign sts    = stsRaw ^ seq.invert;   // Wait states stay while moc is low

    always_comb begin
        case (seq.next)
            nEncoder:    src = srcEncoder;
            nFetch:      src = srcFetch;
            nCtrlReg:    src = srcCtrlReg;
            nIncr:       src = srcIncr;
            nStsCrEnc:   src = sts ? srcCtrlReg : srcEncoder;
            nStsCrInc:   src = sts ? srcCtrlReg : srcIncr;
            nStsEncInc:  src = sts ? srcEncoder : srcIncr;
            nStsCrFetch: src = sts ? srcCtrlReg : srcFetch;
            default:     src = srcFetch;
        endcase
    end

    always_comb begin
        case (src)
            srcEncoder: nextState = startState;
            srcFetch:   nextState = sFetchAddr;
            srcCtrlReg: nextState = seq.crAddress;
            srcIncr:    nextState = microState'(currentState + 1'b1);
            default:    nextState = sFetchAddr;
        endcase
    end

endmodule

// File: controlUnit.sv
`include "cu_consts.svh"

module controlUnit (
    input  logic                   CLK,
    input  logic                   CLR,
    input  logic [`CU_INSTR_W-1:0] instr,
    input  logic                   moc,
    input  logic                   condTrue,
    output cuPkg::microState       currentState,
    output logic                   rfLoad,
    output logic                   irLoad,
    output logic                   marLoad,
    output logic                   mdrLoad,
    output logic                   srLoad,
    output logic                   memWrite,
    output logic                   memValid,
    output cuPkg::aluOp            aluOp
);
    import cuPkg::*;

    microState startState;
    microState nextState;
    ctrlWord   ctrl;

    seqIf seqBus ();

    instrDecoder i_instrDecoder (
        .instr      (instr),
        .startState (startState)
    );

    controlStore i_controlStore (
        .CLK          (CLK),
        .CLR          (CLR),
        .nextState    (nextState),
        .currentState (currentState),
        .seq          (seqBus.store),
        .ctrl         (ctrl)
    );

    microSequencer i_microSequencer (
        .seq          (seqBus.seq),
        .currentState (currentState),
        .startState   (startState),
        .moc          (moc),
        .condTrue     (condTrue),
        .nextState    (nextState)
    );

    assign rfLoad   = ctrl.rfLoad;
    assign irLoad   = ctrl.irLoad;
    assign marLoad  = ctrl.marLoad;
    assign mdrLoad  = ctrl.mdrLoad;
    assign srLoad   = ctrl.srLoad;
    assign memWrite = ctrl.memWrite;
    assign memValid = ctrl.memValid;    // Memory request, answered by moc
    assign aluOp    = ctrl.aluOp;

endmodule

// File: clkGen.sv
module clkGen (
    output logic CLK
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam realtime HalfPeriod = 5ns;   // 10 ns period

    initial begin
        CLK = 1'b0;
    end

    always #(HalfPeriod) CLK = ~CLK;

endmodule

// File: controlUnit_assertions.sv
module controlUnit_assertions (
    input logic             CLK,
    input logic             CLR,
    input cuPkg::microState currentState,
    input cuPkg::microState nextState,
    input cuPkg::ctrlWord   ctrl
);
    timeunit 1ns;
    timeprecision 100ps;
    import cuPkg::*;

    resetIdle: assert property (@(posedge CLK) (currentState == sReset) |-> (ctrl == '0))
        else $error("A control output is active in the reset state");

    // A wait state hands over only to the next step of its sequence
    memHold: assert property (@(posedge CLK) disable iff (!CLR)
        (ctrl.memValid && nextState != currentState) |->
            (currentState == sFetchRead && nextState == sFetchIr)
            || (currentState == sLoadRead && nextState == sLoadWrite)
            || (currentState == sStoreWrite && nextState == sFetchAddr))
        else $error("A memory wait state was left for a state other than its successor");

    fetchOrder: assert property (@(posedge CLK) disable iff (!CLR)
        (currentState == sFetchIr) |=> (currentState == sCondCheck))
        else $error("The instruction load state was not followed by the condition check");

endmodule

bind controlStore controlUnit_assertions i_controlUnitAssertions (
    .CLK          (CLK),
    .CLR          (CLR),
    .currentState (currentState),
    .nextState    (nextState),
    .ctrl         (ctrl)
);

// File: controlUnit_tb.sv
`include "cu_consts.svh"

module controlUnit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cuPkg::*;

    localparam int WaitLimit = 40;     // Cycles before a wait loop gives up

    logic                   CLK;
    logic                   CLR;
    logic [`CU_INSTR_W-1:0] instr;
    logic                   moc;
    logic                   condTrue;
    microState              currentState;
    logic                   rfLoad;
    logic                   irLoad;
    logic                   marLoad;
    logic                   mdrLoad;
    logic                   srLoad;
    logic                   memWrite;
    logic                   memValid;
    aluOp                   aluSel;

    microState expPath [4];            // Execute states of the current case
    int        caseErrors;
    int        totalErrors;
    int        casesRun;
    int        casesFailed;
    bit        timedOut;

    clkGen i_clkGen (
        .CLK (CLK)
    );

    controlUnit i_controlUnit (
        .CLK          (CLK),
        .CLR          (CLR),
        .instr        (instr),
        .moc          (moc),
        .condTrue     (condTrue),
        .currentState (currentState),
        .rfLoad       (rfLoad),
        .irLoad       (irLoad),
        .marLoad      (marLoad),
        .mdrLoad      (mdrLoad),
        .srLoad       (srLoad),
        .memWrite     (memWrite),
        .memValid     (memValid),
        .aluOp        (aluSel)
    );

    task automatic nextCycle();
        @(posedge CLK);
        #1;                            // Outputs settled, inputs change here
    endtask

    task automatic randomizeCond();
        condTrue = $urandom & 1;
    endtask

    function automatic bit isWaitState(input microState st);
        return (st == sFetchRead) || (st == sLoadRead) || (st == sStoreWrite);
    endfunction

    // ALU operation that each state asks for
    function automatic aluOp aluForState(input microState st);
        case (st)
            sDataProc, sTestComp:           return aluInstr;
            sBranchLink:                    return aluLink;
            sBranch, sLoadAddr, sStoreAddr: return aluAddrCalc;
            sLoadWrite, sStoreData:         return aluPassB;
            default:                        return aluAddFour;
        endcase
    endfunction

    task automatic checkState(input microState exp);
        if (currentState !== exp) begin
            $display("Mismatch at %0t ns: currentState expected %0d (%s) got %0d (%s)",
                $time, exp, exp.name(), currentState, currentState.name());
            caseErrors++;
        end
    endtask

    task automatic checkBit(input string sigName, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch at %0t ns: %s expected %b got %b", $time, sigName, exp, act);
            caseErrors++;
        end
    endtask

    task automatic checkControls();
        bit   addrState;
        bit   rfState;
        bit   mdrState;
        aluOp expAlu;
        addrState = (currentState == sFetchAddr) || (currentState == sLoadAddr)
            || (currentState == sStoreAddr);
        rfState = (currentState == sFetchIr) || (currentState == sDataProc)
            || (currentState == sBranchLink) || (currentState == sBranch)
            || (currentState == sLoadWrite);
        mdrState = (currentState == sFetchRead) || (currentState == sLoadRead)
            || (currentState == sStoreData);
        expAlu = aluForState(currentState);
        checkBit("memValid", isWaitState(currentState), memValid);
        checkBit("memWrite", currentState == sStoreWrite, memWrite);
        checkBit("marLoad", addrState, marLoad);
        checkBit("irLoad", currentState == sFetchIr, irLoad);
        checkBit("rfLoad", rfState, rfLoad);
        checkBit("mdrLoad", mdrState, mdrLoad);
        checkBit("srLoad", currentState == sTestComp, srLoad);
        if (aluSel !== expAlu) begin
            $display("Mismatch at %0t ns: aluOp expected %0d got %0d",
                $time, expAlu, aluSel);
            caseErrors++;
        end
    endtask

    // Holds moc low for delay cycles, then completes the access
    task automatic memWait(input microState waitState, input int delay);
        int cycles;
        cycles = 0;
        while (currentState == waitState && cycles < WaitLimit) begin
            checkControls();
            moc = (cycles >= delay);
            randomizeCond();
            nextCycle();
            cycles++;
        end
        moc = 1'b0;
        if (cycles >= WaitLimit) begin
            $display("Timeout: the unit stayed in %s for %0d cycles", waitState.name(), cycles);
            caseErrors++;
            timedOut = 1'b1;
        end else if (cycles != delay + 1) begin
            $display("Mismatch at %0t ns: cycles in %s expected %0d got %0d",
                $time, waitState.name(), delay + 1, cycles);
            caseErrors++;
        end
    endtask

    task automatic syncToFetch();
        int cycles;
        cycles = 0;
        while (currentState != sFetchAddr && cycles < WaitLimit) begin
            randomizeCond();
            nextCycle();
            cycles++;
        end
        if (currentState != sFetchAddr) begin
            $display("Timeout: the unit did not return to the fetch state");
            caseErrors++;
            timedOut = 1'b1;
        end
    endtask

    task automatic runCase(input logic [`CU_INSTR_W-1:0] code, input int cond,
                           input int delay, input int count);
        syncToFetch();
        if (!timedOut) begin
            instr = code;
            checkControls();
            randomizeCond();
            nextCycle();
            checkState(sFetchRead);
            memWait(sFetchRead, delay);
            checkState(sFetchIr);
            checkControls();
            randomizeCond();
            nextCycle();
            checkState(sCondCheck);
            checkControls();
            condTrue = cond[0];        // The only cycle where it is sampled
            nextCycle();
            for (int i = 0; i < count && !timedOut; i++) begin
                checkState(expPath[i]);
                if (isWaitState(expPath[i])) begin
                    memWait(expPath[i], delay);
                end else begin
                    checkControls();
                    randomizeCond();
                    nextCycle();
                end
            end
            checkState(sFetchAddr);    // Every path ends here
        end
    endtask

    task automatic reportCase(input string name);
        casesRun++;
        totalErrors += caseErrors;
        if (caseErrors == 0) begin
            $display("Test %0d %s: ok", casesRun, name);
        end else begin
            casesFailed++;
            $display("Test %0d %s: %0d errors", casesRun, name, caseErrors);
        end
    endtask

    initial begin
        int                     fd;
        int                     nItems;
        string                  line;
        logic [`CU_INSTR_W-1:0] code;
        int                     cond;
        int                     delay;
        int                     count;
        logic [7:0]             s0;
        logic [7:0]             s1;
        logic [7:0]             s2;
        logic [7:0]             s3;

        CLR         = 1'b0;
        instr       = '0;
        moc         = 1'b0;
        condTrue    = 1'b0;
        caseErrors  = 0;
        totalErrors = 0;
        casesRun    = 0;
        casesFailed = 0;
        timedOut    = 1'b0;
        void'($urandom(32'h81d5));

        repeat (2) begin
            nextCycle();
            checkState(sReset);
            checkControls();
        end
        CLR = 1'b1;
        #1;
        checkState(sReset);            // Still idle until the next edge
        checkControls();
        nextCycle();
        checkState(sFetchAddr);
        reportCase("reset");

        fd = $fopen("controlUnit_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file controlUnit_cases.txt");
            totalErrors++;
        end else begin
            while (!$feof(fd) && !timedOut) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    caseErrors = 0;
                    nItems = $sscanf(line, "%h %d %d %d %h %h %h %h",
                        code, cond, delay, count, s0, s1, s2, s3);
                    if (nItems != 8 || count > 4) begin
                        $display("Malformed case line: %s", line);
                        caseErrors++;
                    end else begin
                        expPath[0] = microState'(s0);
                        expPath[1] = microState'(s1);
                        expPath[2] = microState'(s2);
                        expPath[3] = microState'(s3);
                        runCase(code, cond, delay, count);
                    end
                    reportCase($sformatf("instr %h cond %0d moc delay %0d", code, cond, delay));
                end
            end
            $fclose(fd);
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
            casesRun, casesRun - casesFailed, casesFailed, totalErrors);
        if (totalErrors == 0 && !timedOut && casesRun > 1) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Last resort if a step never returns
    initial begin
        #100000;
        $display("Timeout: the run exceeded its time limit");
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: controlUnit_cases.txt
# instr cond mocDelay count path0 path1 path2 path3
# instr in hex, path holds the execute states in hex, unused slots are ff
# Data processing and test/compare
e0810002 1 0 1 05 ff ff ff
e2811001 1 2 1 05 ff ff ff
e1810002 1 1 1 05 ff ff ff
e1510002 1 0 1 06 ff ff ff
e3110001 1 3 1 06 ff ff ff
# Condition false, no execute state
e0810002 0 1 0 ff ff ff ff
e5912004 0 0 0 ff ff ff ff
eb000010 0 2 0 ff ff ff ff
# Branch and branch with link
ea000004 1 0 1 08 ff ff ff
eb000010 1 1 2 07 08 ff ff
# Loads with offset addressing
e5912004 1 0 3 09 0a 0b ff
e5912004 1 3 3 09 0a 0b ff
e7912003 1 1 3 09 0a 0b ff
# Stores with offset addressing
e5812004 1 0 3 0c 0d 0e ff
e5812004 1 2 3 0c 0d 0e ff
e7812003 1 4 3 0c 0d 0e ff
# Unsupported forms restart through the reset state
e5b12004 1 0 1 00 ff ff ff
e4912004 1 0 1 00 ff ff ff
e8bd0001 1 1 1 00 ff ff ff
ec000000 1 0 1 00 ff ff ff
ef000000 1 0 1 00 ff ff ff
# Back to normal flow after a restart
e1510002 1 1 1 06 ff ff ff

// File: build.f
+incdir+.
cu_pkg.sv
seqIf.sv
instrDecoder.sv
controlStore.sv
microSequencer.sv
controlUnit.sv
clkGen.sv
controlUnit_assertions.sv
controlUnit_tb.sv
